/* compile.f */
hw/colmix_pkg.sv
hw/prio_table.sv
hw/layer_align.sv
hw/palette_mix.sv
hw/colmix_top.sv
tb/colmix_properties.sv
tb/colmix_tb.sv

/* hw/colmix_pkg.sv */
// shared vector typedefs and packed structs for the colour mixer
package colmix_pkg;

    // one layer pixel, low nibble is the colour index
    // index 0 means transparent
    typedef logic [7:0] pixel_t;

    // winning layer code
    // 0 ba0, 1 obj, 2 ba1, 3 ba2
    typedef logic [1:0] layer_sel_t;

    // priority table address
    typedef logic [9:0] prio_addr_t;

    // palette address, layer code on top of the pixel
    typedef logic [9:0] pal_addr_t;

    // one colour channel
    typedef logic [7:0] color_t;

    // cpu data bus
    typedef logic [15:0] cpu_word_t;

    // layer enables, bit 0 ba0, 1 ba1, 2 ba2, 3 obj
    typedef logic [3:0] layer_mask_t;

    // cpu priority mode
    typedef logic [2:0] prisel_t;

    // the four layers of one screen pixel
    typedef struct packed {
        pixel_t ba0;
        pixel_t ba1;
        pixel_t ba2;
        pixel_t obj;
    } layer_pixels_t;

    // blanking levels, both active low
    typedef struct packed {
        logic lhbl;
        logic lvbl;
    } blank_t;

    // final colour
    typedef struct packed {
        color_t red;
        color_t green;
        color_t blue;
    } rgb_t;

endpackage

/* hw/colmix_top.sv */
// colmix_top: colour mixer top level joining prio_table, layer_align and palette_mix
`timescale 1ns/100ps

module colmix_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  logic                      LHBL,
    input  logic                      LVBL,
    input  colmix_pkg::layer_pixels_t pxl,
    input  colmix_pkg::prisel_t       prisel,
    input  colmix_pkg::layer_mask_t   gfx_en,
    // cpu port
    input  logic [1:0]                pal_cs,
    input  colmix_pkg::pal_addr_t     cpu_addr,
    input  colmix_pkg::cpu_word_t     cpu_dout,
    input  logic [1:0]                dsn,
    output colmix_pkg::cpu_word_t     cpu_din,
    // loader port
    input  colmix_pkg::prio_addr_t    prog_addr,
    input  colmix_pkg::layer_sel_t    prom_din,
    input  logic                      prom_we,
    // video out
    output colmix_pkg::rgb_t          rgb,
    output logic                      LHBL_dly,
    output logic                      LVBL_dly
);
    import colmix_pkg::*;

    blank_t        blank_in;
    blank_t        blank_q;
    blank_t        blank_dly;
    layer_sel_t    sel;
    layer_pixels_t pxl_q;

    assign blank_in.lhbl = LHBL;
    assign blank_in.lvbl = LVBL;
    assign LHBL_dly      = blank_dly.lhbl;
    assign LVBL_dly      = blank_dly.lvbl;

    prio_table u_prio (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pxl       (pxl),
        .prisel    (prisel),
        .gfx_en    (gfx_en),
        .prog_addr (prog_addr),
        .prom_din  (prom_din),
        .prom_we   (prom_we),
        .sel       (sel)
    );

    layer_align u_align (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .pxl     (pxl),
        .blank   (blank_in),
        .pxl_q   (pxl_q),
        .blank_q (blank_q)
    );

    palette_mix u_mix (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .sel       (sel),
        .pxl_q     (pxl_q),
        .blank_q   (blank_q),
        .pal_cs    (pal_cs),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .dsn       (dsn),
        .cpu_din   (cpu_din),
        .rgb       (rgb),
        .blank_dly (blank_dly)
    );

endmodule

/* hw/layer_align.sv */
// layer_align: stage 1 register for layer pixels and blanking levels
`timescale 1ns/100ps

module layer_align (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  colmix_pkg::layer_pixels_t pxl,
    input  colmix_pkg::blank_t        blank,
    output colmix_pkg::layer_pixels_t pxl_q,
    output colmix_pkg::blank_t        blank_q
);

    // same step as the priority lookup
    // so sel and pixels arrive together at the mixer
    always_ff @(posedge clk) begin
        if (rst) begin
            pxl_q   <= '0;
            blank_q <= '0;
        end else if (pxl_cen) begin
            pxl_q   <= pxl;
            blank_q <= blank;
        end
    end

endmodule

/* hw/palette_mix.sv */
// palette_mix: layer mux, red/green and blue palette RAMs, blanked colour output
`timescale 1ns/100ps

module palette_mix (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  colmix_pkg::layer_sel_t    sel,
    input  colmix_pkg::layer_pixels_t pxl_q,
    input  colmix_pkg::blank_t        blank_q,
    input  logic [1:0]                pal_cs,
    input  colmix_pkg::pal_addr_t     cpu_addr,
    input  colmix_pkg::cpu_word_t     cpu_dout,
    input  logic [1:0]                dsn,
    output colmix_pkg::cpu_word_t     cpu_din,
    output colmix_pkg::rgb_t          rgb,
    output colmix_pkg::blank_t        blank_dly
);
    import colmix_pkg::*;

    // red in the low byte, green in the high byte
    cpu_word_t ram_gr [1024];
    color_t    ram_b  [1024];

    logic [1:0] we_gr;
    logic       we_b;

    pixel_t    win_pxl;
    pal_addr_t pal_addr;
    blank_t    blank_d2;

    // cpu readback
    cpu_word_t cpu_gr_q;
    color_t    cpu_b_q;
    logic      gr_cs_q;

    // video side read
    cpu_word_t pal_gr;
    color_t    pal_b;

    // byte lanes enabled by low dsn bits
    assign we_gr = ~dsn & {2{pal_cs[0]}};
    // blue only on the low lane
    assign we_b  = ~dsn[0] & pal_cs[1];

    always_comb begin
        case (sel)
            2'd0: win_pxl = pxl_q.ba0;
            2'd1: win_pxl = pxl_q.obj;
            2'd2: win_pxl = pxl_q.ba1;
            default: win_pxl = pxl_q.ba2;
        endcase
    end

    // cpu port of both RAMs
    always_ff @(posedge clk) begin
        if (we_gr[0]) begin
            ram_gr[cpu_addr][7:0] <= cpu_dout[7:0];
        end
        if (we_gr[1]) begin
            ram_gr[cpu_addr][15:8] <= cpu_dout[15:8];
        end
        if (we_b) begin
            ram_b[cpu_addr] <= cpu_dout[7:0];
        end
        cpu_gr_q <= ram_gr[cpu_addr];
        cpu_b_q  <= ram_b[cpu_addr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gr_cs_q <= 1'b0;
        end else begin
            gr_cs_q <= pal_cs[0];
        end
    end

    // unused upper byte of the blue RAM reads as ones
    assign cpu_din = gr_cs_q ? cpu_gr_q : {8'hff, cpu_b_q};

    // video port, contents as seen at stage 3
    assign pal_gr = ram_gr[pal_addr];
    assign pal_b  = ram_b[pal_addr];

    // stage 2 and stage 3
    always_ff @(posedge clk) begin
        if (rst) begin
            pal_addr  <= '0;
            blank_d2  <= '0;
            blank_dly <= '0;
            rgb       <= '0;
        end else if (pxl_cen) begin
            pal_addr  <= {sel, win_pxl};
            blank_d2  <= blank_q;
            blank_dly <= blank_d2;
            // black when either level is active
            if (blank_d2.lhbl && blank_d2.lvbl) begin
                rgb.red   <= pal_gr[7:0];
                rgb.green <= pal_gr[15:8];
                rgb.blue  <= pal_b;
            end else begin
                rgb <= '0;
            end
        end
    end

endmodule

/* hw/prio_table.sv */
// prio_table: priority address build, loadable 1024x2 layer select table
`timescale 1ns/100ps

module prio_table (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  colmix_pkg::layer_pixels_t pxl,
    input  colmix_pkg::prisel_t       prisel,
    input  colmix_pkg::layer_mask_t   gfx_en,
    input  colmix_pkg::prio_addr_t    prog_addr,
    input  colmix_pkg::layer_sel_t    prom_din,
    input  logic                      prom_we,
    output colmix_pkg::layer_sel_t    sel
);
    import colmix_pkg::*;

    // transparency flags, disabled layers count as empty
    logic ba0_tr;
    logic ba1_tr;
    logic ba2_tr;
    logic obj_tr;

    prio_addr_t prio_addr;

    // table written by the loader
    layer_sel_t table_mem [1024];

    assign ba0_tr = ~|pxl.ba0[3:0] | ~gfx_en[0];
    assign ba1_tr = ~|pxl.ba1[3:0] | ~gfx_en[1];
    assign ba2_tr = ~|pxl.ba2[3:0] | ~gfx_en[2];
    assign obj_tr = ~|pxl.obj[3:0] | ~gfx_en[3];

    // bit order matches the original prom wiring
    assign prio_addr = {
        prisel,
        ba0_tr,
        pxl.obj[7],
        obj_tr,
        pxl.ba1[7],
        pxl.ba1[3],
        ba1_tr,
        ba2_tr
    };

    // loader port
    always_ff @(posedge clk) begin
        if (prom_we) begin
            table_mem[prog_addr] <= prom_din;
        end
    end

    // stage 1 lookup
    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= '0;
        end else if (pxl_cen) begin
            sel <= table_mem[prio_addr];
        end
    end

endmodule

/* tb/colmix_properties.sv */
// concurrent output assertions bound to the colour mixer top level
`timescale 1ns/100ps

module colmix_properties (
    input logic             clk,
    input logic             rst,
    input logic             pxl_cen,
    input colmix_pkg::rgb_t rgb,
    input logic             lhbl_dly,
    input logic             lvbl_dly,
    input logic [1:0]       pal_cs
);

    // count of failed assertions
    int err_count = 0;

    // colour forced to black while either blanking level is low
    a_black_when_blanked: assert property (@(posedge clk) disable iff (rst)
        (!lhbl_dly || !lvbl_dly) |-> (rgb == '0))
        else begin
            $error("rgb not black during blanking");
            err_count++;
        end

    // outputs hold on edges without a pixel strobe
    a_hold_without_cen: assert property (@(posedge clk) disable iff (rst)
        !pxl_cen |=> ($stable(rgb) && $stable(lhbl_dly) && $stable(lvbl_dly)))
        else begin
            $error("outputs moved on an edge without pxl_cen");
            err_count++;
        end

    // pipeline cleared by reset
    a_low_after_reset: assert property (@(posedge clk)
        rst |=> (rgb == '0 && !lhbl_dly && !lvbl_dly))
        else begin
            $error("outputs not cleared after reset");
            err_count++;
        end

    // only one palette RAM selected at a time
    a_single_cs: assert property (@(posedge clk) pal_cs != 2'b11)
        else begin
            $error("both palette chip selects active");
            err_count++;
        end

endmodule

bind colmix_top colmix_properties props0 (
    .clk      (clk),
    .rst      (rst),
    .pxl_cen  (pxl_cen),
    .rgb      (rgb),
    .lhbl_dly (LHBL_dly),
    .lvbl_dly (LVBL_dly),
    .pal_cs   (pal_cs)
);

/* tb/colmix_tb.sv */
// clock, reset, LFSR stimulus, reference model, compare tasks and result report
`timescale 1ns/100ps

module colmix_tb;
    import colmix_pkg::*;

    // one pixel in flight through the model pipeline
    typedef struct packed {
        pal_addr_t addr;
        blank_t    blank;
    } pipe_ent_t;

    logic          clk;
    logic          rst;
    logic          pxl_cen;
    logic          lhbl;
    logic          lvbl;
    layer_pixels_t pxl;
    prisel_t       prisel;
    layer_mask_t   gfx_en;
    logic [1:0]    pal_cs;
    pal_addr_t     cpu_addr;
    cpu_word_t     cpu_dout;
    logic [1:0]    dsn;
    cpu_word_t     cpu_din;
    prio_addr_t    prog_addr;
    layer_sel_t    prom_din;
    logic          prom_we;
    rgb_t          rgb;
    logic          lhbl_dly;
    logic          lvbl_dly;
    logic          checking;

    // model state
    layer_sel_t    m_table [1024];
    cpu_word_t     m_gr [1024];
    color_t        m_b [1024];
    pipe_ent_t     pipe_q [$];
    rgb_t          exp_rgb;
    blank_t        exp_blank;
    layer_sel_t    exp_sel;
    cpu_word_t     exp_word;
    logic          word_due;
    int            steps;
    logic [15:0]   lfsr;

    colmix_top dut0 (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .LHBL(lhbl), .LVBL(lvbl),
        .pxl(pxl), .prisel(prisel), .gfx_en(gfx_en),
        .pal_cs(pal_cs), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .dsn(dsn),
        .cpu_din(cpu_din), .prog_addr(prog_addr), .prom_din(prom_din),
        .prom_we(prom_we), .rgb(rgb), .LHBL_dly(lhbl_dly), .LVBL_dly(lvbl_dly)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // fibonacci lfsr with taps x^16 x^14 x^13 x^11
    // one shift per returned bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // empty index or layer switched off
    function automatic logic is_clear(pixel_t p, logic en);
        return (p[3:0] == 4'd0) || !en;
    endfunction

    function automatic prio_addr_t model_prio_addr(layer_pixels_t p, prisel_t ps,
                                                   layer_mask_t en);
        return {ps, is_clear(p.ba0, en[0]), p.obj[7], is_clear(p.obj, en[3]),
                p.ba1[7], p.ba1[3], is_clear(p.ba1, en[1]), is_clear(p.ba2, en[2])};
    endfunction

    // pixel of the layer named by a select code
    function automatic pixel_t model_layer_pixel(layer_pixels_t p, layer_sel_t s);
        if (s == 2'd0) return p.ba0;
        if (s == 2'd1) return p.obj;
        if (s == 2'd2) return p.ba1;
        return p.ba2;
    endfunction

    task automatic fail_now(string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_rgb(rgb_t got, rgb_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Fail at %0t: rgb is %06h, expected %06h", $time, got, exp));
        end
    endtask

    task automatic check_blank(blank_t got, blank_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Fail at %0t: delayed blanking is %02b, expected %02b",
                               $time, got, exp));
        end
    endtask

    task automatic check_word(cpu_word_t got, cpu_word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Fail at %0t: cpu readback is %04h, expected %04h",
                               $time, got, exp));
        end
    endtask

    task automatic check_sel(layer_sel_t got, layer_sel_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Fail at %0t: layer select is %0d, expected %0d",
                               $time, got, exp));
        end
    endtask

    // reference model steps on the same edge as the DUT
    always @(posedge clk) begin
        pipe_ent_t ent;
        if (rst) begin
            pipe_q.delete();
            // two stages hold cleared entries after reset
            pipe_q.push_back('0);
            pipe_q.push_back('0);
            exp_rgb   = '0;
            exp_blank = '0;
            exp_sel   = '0;
            word_due  = 1'b0;
            steps    <= 0;
        end else begin
            if (pxl_cen) begin
                exp_sel        = m_table[model_prio_addr(pxl, prisel, gfx_en)];
                ent.addr       = {exp_sel, model_layer_pixel(pxl, exp_sel)};
                ent.blank.lhbl = lhbl;
                ent.blank.lvbl = lvbl;
                pipe_q.push_back(ent);
                // oldest entry reaches stage 3 with the palette as it is now
                ent       = pipe_q.pop_front();
                exp_blank = ent.blank;
                exp_rgb   = '0;
                if (ent.blank.lhbl && ent.blank.lvbl) begin
                    exp_rgb.red   = m_gr[ent.addr][7:0];
                    exp_rgb.green = m_gr[ent.addr][15:8];
                    exp_rgb.blue  = m_b[ent.addr];
                end
                steps <= steps + 1;
            end
            // readback shows contents before this edge's write
            word_due = (pal_cs != 2'b00) && (dsn == 2'b11);
            if (pal_cs[0]) begin
                exp_word = m_gr[cpu_addr];
            end else begin
                exp_word = {8'hff, m_b[cpu_addr]};
            end
        end
        // RAM and table writes ignore reset
        if (pal_cs[0] && !dsn[0]) begin
            m_gr[cpu_addr][7:0] = cpu_dout[7:0];
        end
        if (pal_cs[0] && !dsn[1]) begin
            m_gr[cpu_addr][15:8] = cpu_dout[15:8];
        end
        if (pal_cs[1] && !dsn[0]) begin
            m_b[cpu_addr] = cpu_dout[7:0];
        end
        if (prom_we) begin
            m_table[prog_addr] = prom_din;
        end
    end

    // outputs settled half a cycle after the edge
    always @(negedge clk) begin
        blank_t got_blank;
        if (dut0.props0.err_count != 0) begin
            fail_now("a bound assertion on the mixer outputs failed");
        end
        if (checking) begin
            got_blank.lhbl = lhbl_dly;
            got_blank.lvbl = lvbl_dly;
            check_rgb(rgb, exp_rgb);
            check_blank(got_blank, exp_blank);
            check_sel(dut0.sel, exp_sel);
            if (word_due) begin
                check_word(cpu_din, exp_word);
            end
        end
    end

    task automatic cpu_access(logic [1:0] cs, pal_addr_t addr, cpu_word_t data,
                              logic [1:0] lanes);
        @(posedge clk);
        pal_cs   <= cs;
        cpu_addr <= addr;
        cpu_dout <= data;
        dsn      <= lanes;
    endtask

    // random pixels until n more strobes went through
    task automatic run_video(int n, logic rnd_blank, logic rnd_mask);
        int target;
        int cycles;
        target = steps + n;
        cycles = 0;
        while (steps < target) begin
            @(posedge clk);
            pxl_cen <= 1'(rand_bits(1));
            pxl     <= layer_pixels_t'(rand_bits(32));
            prisel  <= prisel_t'(rand_bits(3));
            gfx_en  <= rnd_mask ? layer_mask_t'(rand_bits(4)) : 4'hf;
            lhbl    <= rnd_blank ? 1'(rand_bits(1)) : 1'b1;
            lvbl    <= rnd_blank ? 1'(rand_bits(1)) : 1'b1;
            cycles++;
            if (cycles > 20 * n + 100) begin
                fail_now("timeout: pixel pipeline stopped advancing");
            end
        end
        @(posedge clk);
        pxl_cen <= 1'b0;
    endtask

    // inputs keep moving while the strobe stays low
    task automatic idle_stretch(int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            pxl_cen <= 1'b0;
            pxl     <= layer_pixels_t'(rand_bits(32));
            lhbl    <= 1'(rand_bits(1));
            lvbl    <= 1'(rand_bits(1));
        end
    endtask

    initial begin
        pal_addr_t a;
        lfsr = 16'd50037;
        rst = 1'b1;
        pxl_cen = 1'b0;
        lhbl = 1'b0;
        lvbl = 1'b0;
        pxl = '0;
        prisel = '0;
        gfx_en = '0;
        pal_cs = '0;
        cpu_addr = '0;
        cpu_dout = '0;
        dsn = 2'b11;
        prog_addr = '0;
        prom_din = '0;
        prom_we = 1'b0;
        checking = 1'b0;
        repeat (2) @(posedge clk);
        rst      <= 1'b0;
        checking <= 1'b1;
        // whole priority table from the loader
        for (int i = 0; i < 1024; i++) begin
            @(posedge clk);
            prom_we   <= 1'b1;
            prog_addr <= prio_addr_t'(i);
            prom_din  <= layer_sel_t'(rand_bits(2));
        end
        @(posedge clk);
        prom_we <= 1'b0;
        // full word fill of both palettes
        for (int i = 0; i < 1024; i++) begin
            cpu_access(2'b01, pal_addr_t'(i), cpu_word_t'(rand_bits(16)), 2'b00);
            cpu_access(2'b10, pal_addr_t'(i), cpu_word_t'(rand_bits(16)),
                       {1'(rand_bits(1)), 1'b0});
        end
        cpu_access(2'b00, '0, '0, 2'b11);
        run_video(300, 1'b0, 1'b0);
        // byte lane writes with a read of the same word after each
        for (int i = 0; i < 200; i++) begin
            a = pal_addr_t'(rand_bits(10));
            cpu_access(2'b01, a, cpu_word_t'(rand_bits(16)), 2'(rand_bits(2)));
            cpu_access(2'b01, a, '0, 2'b11);
        end
        for (int i = 0; i < 200; i++) begin
            a = pal_addr_t'(rand_bits(10));
            cpu_access(2'b10, a, cpu_word_t'(rand_bits(16)), 2'(rand_bits(2)));
            cpu_access(2'b10, a, '0, 2'b11);
        end
        cpu_access(2'b00, '0, '0, 2'b11);
        run_video(300, 1'b0, 1'b1);
        run_video(300, 1'b1, 1'b1);
        for (int i = 0; i < 10; i++) begin
            run_video(20, 1'b1, 1'b1);
            idle_stretch(int'(rand_bits(5)) + 1);
        end
        run_video(20, 1'b0, 1'b0);
        @(posedge clk);
        if (dut0.props0.err_count != 0) begin
            fail_now("a bound assertion on the mixer outputs failed");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule
